// File: common/rvIsaPkg.sv
package rvIsaPkg;

    // Field widths of the base ISA
    localparam int XLEN     = 32;
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;
    localparam int REG_W    = 5;  // 32 architectural registers

    typedef logic [XLEN-1:0]  wordT;     // Data word, also used for addresses
    typedef logic [XLEN-1:0]  instT;     // Raw instruction word
    typedef logic [REG_W-1:0] regAddrT;  // Register index x0..x31

    typedef logic [FUNCT3_W-1:0] funct3T;
    typedef logic [FUNCT7_W-1:0] funct7T;

    // Major opcodes of the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        OP_R      = 7'b0110011,  // add sub and or xor slt
        OP_I      = 7'b0010011,  // Register-immediate ALU ops
        OP_LOAD   = 7'b0000011,  // lw only
        OP_STORE  = 7'b0100011,  // sw only
        OP_BRANCH = 7'b1100011   // beq bne
    } opcodeT;

    // funct3 for the ALU group
    localparam funct3T F3_ADDSUB = 3'b000;
    localparam funct3T F3_SLT    = 3'b010;
    localparam funct3T F3_XOR    = 3'b100;
    localparam funct3T F3_OR     = 3'b110;
    localparam funct3T F3_AND    = 3'b111;

    // funct3 for branches
    localparam funct3T F3_BEQ = 3'b000;
    localparam funct3T F3_BNE = 3'b001;

    // funct7 for R-type, bit 30 selects sub
    localparam funct7T F7_BASE = 7'b0000000;
    localparam funct7T F7_SUB  = 7'b0100000;

endpackage

// File: common/cpuCtrlPkg.sv
package cpuCtrlPkg;

    // ALU operation, chosen by the decoder
    typedef enum logic [2:0] {
        ADD,
        SUB,  // Also used for branch compare
        AND,
        OR,
        XOR,
        SLT   // Signed less-than, result is 0 or 1
    } aluOpT;

    // Writeback source
    typedef enum logic {
        WB_ALU,  // R-type, I-type
        WB_MEM   // lw
    } wbSelT;

    // Branch condition evaluated on the ALU zero flag
    typedef enum logic [1:0] {
        NONE,  // Not a branch
        EQ,    // beq, taken on zero
        NE     // bne, taken on nonzero
    } brCondT;

endpackage

// File: common/ctrlIf.sv
`timescale 1ns/1ps

// Decoded control bundle, one instruction's worth
interface ctrlIf
    import rvIsaPkg::*, cpuCtrlPkg::*;
();

    aluOpT  aluOp;
    logic   aluSrcImm;  // Operand B from imm instead of rs2
    logic   regWrite;
    logic   memWrite;
    wbSelT  wbSel;
    brCondT brCond;
    wordT   imm;        // Sign-extended, B format already shifted

    modport driver (
        output aluOp, aluSrcImm, regWrite, memWrite, wbSel, brCond, imm
    );

    // Read-only view for the datapath and the top-level glue
    modport user (
        input aluOp, aluSrcImm, regWrite, memWrite, wbSel, brCond, imm
    );

endinterface

// File: fetch/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit
    import rvIsaPkg::*;
#(
    parameter int IMEM_DEPTH = 256
) (
    input  logic CLK,
    input  logic rst,
    input  logic run,
    input  logic loadEn,
    input  wordT loadAddr,   // Word index, not byte address
    input  instT loadData,
    input  logic takeBranch,
    input  wordT imm,
    output wordT pc,
    output instT inst
);

    localparam int IW = $clog2(IMEM_DEPTH);  // Index bits

    instT imem [IMEM_DEPTH];  // Program store, filled through the load port
    wordT pcPlus4;
    wordT pcTarget;
    wordT nextPc;

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + imm;    // Branch target, imm is byte offset
    assign nextPc   = takeBranch ? pcTarget : pcPlus4;

    // PC register
    always_ff @(posedge CLK) begin
        if (rst) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;
        end
    end

    // Load port, writes one word per edge
    always_ff @(posedge CLK) begin
        if (loadEn) begin
            imem[loadAddr[IW-1:0]] <= loadData;  // Wraps modulo depth
        end
    end

    // Combinational fetch, byte PC to word index
    assign inst = imem[pc[IW+1:2]];

endmodule

// File: logic/instDecoder.sv
`timescale 1ns/1ps

module instDecoder
    import rvIsaPkg::*, cpuCtrlPkg::*;
(
    input  instT         inst,
    ctrlIf.driver        ctrl
);

    opcodeT opcode;
    funct3T funct3;
    funct7T funct7;
    wordT   immI;
    wordT   immS;
    wordT   immB;
    aluOpT  aluFn;      // ALU op from funct fields
    logic   aluFnOk;    // funct combination is supported

    assign opcode = opcodeT'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Immediates, all sign-extended from bit 31
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // ALU control from funct3/funct7
    always_comb begin
        aluFn   = ADD;
        aluFnOk = 1'b1;
        case (funct3)
            F3_ADDSUB: begin
                // sub only exists as R-type
                if (opcode == OP_R && funct7 == F7_SUB) begin
                    aluFn = SUB;
                end else begin
                    aluFn = ADD;
                end
            end
            F3_SLT:  aluFn = SLT;
            F3_XOR:  aluFn = XOR;
            F3_OR:   aluFn = OR;
            F3_AND:  aluFn = AND;
            default: aluFnOk = 1'b0;  // Shifts, sltu
        endcase
        // R-type needs a known funct7
        if (opcode == OP_R && funct7 != F7_BASE && funct7 != F7_SUB) begin
            aluFnOk = 1'b0;
        end
        if (opcode == OP_R && funct7 == F7_SUB && funct3 != F3_ADDSUB) begin
            aluFnOk = 1'b0;
        end
    end

    // Main control
    always_comb begin
        // No-op defaults, nothing written
        ctrl.aluOp     = ADD;
        ctrl.aluSrcImm = 1'b0;
        ctrl.regWrite  = 1'b0;
        ctrl.memWrite  = 1'b0;
        ctrl.wbSel     = WB_ALU;
        ctrl.brCond    = NONE;
        ctrl.imm       = '0;
        case (opcode)
            OP_R: begin
                ctrl.aluOp    = aluFn;
                ctrl.regWrite = aluFnOk;
            end
            OP_I: begin
                ctrl.aluOp     = aluFn;
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = aluFnOk;
                ctrl.imm       = immI;
            end
            OP_LOAD: begin
                ctrl.aluSrcImm = 1'b1;      // Address = rs1 + imm
                ctrl.regWrite  = 1'b1;
                ctrl.wbSel     = WB_MEM;
                ctrl.imm       = immI;
            end
            OP_STORE: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.imm       = immS;
            end
            OP_BRANCH: begin
                ctrl.aluOp = SUB;           // Zero flag means equal
                ctrl.imm   = immB;
                case (funct3)
                    F3_BEQ:  ctrl.brCond = EQ;
                    F3_BNE:  ctrl.brCond = NE;
                    default: ctrl.brCond = NONE;  // blt and friends not supported
                endcase
            end
            default: ;  // Unknown opcode, stays a no-op
        endcase
    end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile
    import rvIsaPkg::*;
(
    input  logic    CLK,
    input  logic    rst,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  regAddrT rd,
    input  logic    we,
    input  wordT    wd,
    output wordT    rs1Data,
    output wordT    rs2Data
);

    wordT regs [32];

    // Single write port, x0 never written
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // Async reads, x0 forced to zero
    assign rs1Data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit
    import rvIsaPkg::*, cpuCtrlPkg::*;
(
    ctrlIf.user  ctrl,
    input  wordT rs1Data,
    input  wordT rs2Data,
    output wordT result,
    output logic takeBranch
);

    wordT opB;
    logic zero;

    assign opB = ctrl.aluSrcImm ? ctrl.imm : rs2Data;  // Second operand mux

    always_comb begin
        case (ctrl.aluOp)
            ADD:     result = rs1Data + opB;
            SUB:     result = rs1Data - opB;
            AND:     result = rs1Data & opB;
            OR:      result = rs1Data | opB;
            XOR:     result = rs1Data ^ opB;
            // Signed compare
            SLT:     result = {31'b0, $signed(rs1Data) < $signed(opB)};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

    // Branch resolution
    always_comb begin
        case (ctrl.brCond)
            EQ:      takeBranch = zero;
            NE:      takeBranch = !zero;
            default: takeBranch = 1'b0;
        endcase
    end

endmodule

// File: logic/dataMem.sv
`timescale 1ns/1ps

module dataMem
    import rvIsaPkg::*;
#(
    parameter int DMEM_DEPTH = 64
) (
    input  logic CLK,
    input  logic rst,
    input  logic we,
    input  wordT addr,   // Byte address, low two bits ignored
    input  wordT wd,
    output wordT rd
);

    localparam int DW = $clog2(DMEM_DEPTH);

    wordT mem [DMEM_DEPTH];
    logic [DW-1:0] idx;

    assign idx = addr[DW+1:2];  // Wraps modulo depth

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[idx] <= wd;
        end
    end

    assign rd = mem[idx];  // Comb read, lw finishes same cycle

endmodule

// File: logic/singleCpu.sv
`timescale 1ns/1ps

module singleCpu
    import rvIsaPkg::*, cpuCtrlPkg::*;
#(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 64
) (
    input  logic    CLK,
    input  logic    rst,
    input  logic    run,
    input  logic    loadEn,
    input  wordT    loadAddr,
    input  instT    loadData,
    output logic    retireValid,
    output wordT    pc,
    output logic    wbEn,
    output regAddrT wbReg,
    output wordT    wbData,
    output logic    storeEn,
    output wordT    storeAddr,
    output wordT    storeData
);

    ctrlIf ctrl();

    instT inst;
    wordT rs1Data;
    wordT rs2Data;
    wordT aluResult;
    wordT memData;
    logic takeBranch;
    logic active;    // Core is retiring this cycle

    assign active = run && !rst;

    fetchUnit #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) uFetch (
        .CLK        (CLK),
        .rst        (rst),
        .run        (run),
        .loadEn     (loadEn),
        .loadAddr   (loadAddr),
        .loadData   (loadData),
        .takeBranch (takeBranch),
        .imm        (ctrl.imm),
        .pc         (pc),
        .inst       (inst)
    );

    instDecoder uDec (
        .inst (inst),
        .ctrl (ctrl.driver)
    );

    regFile uRegs (
        .CLK     (CLK),
        .rst     (rst),
        .rs1     (inst[19:15]),
        .rs2     (inst[24:20]),
        .rd      (wbReg),
        .we      (wbEn),
        .wd      (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    aluUnit uAlu (
        .ctrl       (ctrl.user),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .result     (aluResult),
        .takeBranch (takeBranch)
    );

    dataMem #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) uDmem (
        .CLK  (CLK),
        .rst  (rst),
        .we   (storeEn),
        .addr (aluResult),
        .wd   (rs2Data),
        .rd   (memData)
    );

    // Writeback select and write qualification
    assign wbReg  = inst[11:7];
    assign wbData = (ctrl.wbSel == WB_MEM) ? memData : aluResult;
    assign wbEn   = active && ctrl.regWrite && (wbReg != '0);  // x0 writes hidden

    assign storeEn   = active && ctrl.memWrite;
    assign storeAddr = aluResult;
    assign storeData = rs2Data;

    assign retireValid = active;  // One instruction per edge while running

endmodule

// File: bench/singleCpu_asserts.sv
`timescale 1ns/1ps

module singleCpu_asserts
    import rvIsaPkg::*;
(
    input logic    CLK,
    input logic    rst,
    input logic    run,
    input logic    retireValid,
    input logic    wbEn,
    input regAddrT wbReg,
    input logic    storeEn,
    input wordT    pc
);

    // x0 target hidden from the writeback port
    noX0Write: assert property (@(posedge CLK) disable iff (rst) !(wbEn && wbReg == '0))
        else $error("wbEn high with wbReg x0");

    // Nothing retires or writes in reset or stall
    quietWhenStopped: assert property (@(posedge CLK)
        (rst || !run) |-> !(retireValid || wbEn || storeEn))
        else $error("activity while rst high or run low");

    pcAligned: assert property (@(posedge CLK) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

bind singleCpu singleCpu_asserts asserts (
    .CLK         (CLK),
    .rst         (rst),
    .run         (run),
    .retireValid (retireValid),
    .wbEn        (wbEn),
    .wbReg       (wbReg),
    .storeEn     (storeEn),
    .pc          (pc)
);

// File: bench/singleCpu_tb.sv
`timescale 1ns/1ps

module singleCpu_tb
    import rvIsaPkg::*;
();

    localparam int IMEM_DEPTH  = 256;
    localparam int DMEM_DEPTH  = 64;
    localparam int NUM_RAND    = 200;
    localparam int PROG_LEN    = NUM_RAND + 1;           // Random part plus end loop
    localparam wordT END_PC    = wordT'(NUM_RAND * 4);
    localparam int CYCLE_LIMIT = PROG_LEN * 2 + 50;      // Load pass plus run pass

    // Instruction kinds
    localparam int K_R  = 0;
    localparam int K_I  = 1;
    localparam int K_LW = 2;
    localparam int K_SW = 3;
    localparam int K_BR = 4;

    logic    CLK;
    logic    rst;
    logic    run;
    logic    loadEn;
    wordT    loadAddr;
    instT    loadData;
    logic    retireValid;
    wordT    pc;
    logic    wbEn;
    regAddrT wbReg;
    wordT    wbData;
    logic    storeEn;
    wordT    storeAddr;
    wordT    storeData;

    // Program kept as fields for the model
    int      kindArr [PROG_LEN];
    int      opArr   [PROG_LEN];  // ALU op 0 to 5 or branch 0 beq 1 bne
    regAddrT rdArr   [PROG_LEN];
    regAddrT rs1Arr  [PROG_LEN];
    regAddrT rs2Arr  [PROG_LEN];
    wordT    immArr  [PROG_LEN];
    instT    progWord[PROG_LEN];
    wordT    modelRegs[32];
    wordT    modelMem [DMEM_DEPTH];
    wordT    modelPc;
    int      cycles;

    singleCpu #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) uut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;  // 8 ns period
    end

    task automatic stopWithError(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            stopWithError($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkReg(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp) begin
            stopWithError($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stopWithError($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic wordT aluModel(input int op, input wordT a, input wordT b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // slt is signed
        endcase
    endfunction

    function automatic logic [2:0] aluFunct3(input int op);
        case (op)
            2: return 3'b111;
            3: return 3'b110;
            4: return 3'b100;
            5: return 3'b010;
            default: return 3'b000;  // add and sub share it
        endcase
    endfunction

    // Encoding straight from the RV32I formats
    function automatic instT encodeInst(input int i);
        wordT imm;
        logic [2:0] f3;
        imm = immArr[i];
        f3  = aluFunct3(opArr[i]);
        case (kindArr[i])
            K_R: return {(opArr[i] == 1) ? 7'b0100000 : 7'b0000000,
                         rs2Arr[i], rs1Arr[i], f3, rdArr[i], 7'b0110011};
            K_I:  return {imm[11:0], rs1Arr[i], f3, rdArr[i], 7'b0010011};
            K_LW: return {imm[11:0], rs1Arr[i], 3'b010, rdArr[i], 7'b0000011};
            K_SW: return {imm[11:5], rs2Arr[i], rs1Arr[i], 3'b010, imm[4:0], 7'b0100011};
            default: return {imm[12], imm[10:5], rs2Arr[i], rs1Arr[i],
                             (opArr[i] == 1) ? 3'b001 : 3'b000, imm[4:1], imm[11], 7'b1100011};
        endcase
    endfunction

    task automatic buildProgram();
        int pick;
        logic signed [11:0] imm12;
        for (int i = 0; i < NUM_RAND; i++) begin
            pick      = $urandom_range(0, 99);
            rdArr[i]  = regAddrT'($urandom_range(0, 31));  // x0 allowed as target
            rs1Arr[i] = regAddrT'($urandom_range(0, 31));
            rs2Arr[i] = regAddrT'($urandom_range(0, 31));
            opArr[i]  = 0;
            immArr[i] = '0;
            if (pick < 30) begin
                kindArr[i] = K_R;
                opArr[i]   = $urandom_range(0, 5);
            end else if (pick < 60) begin
                kindArr[i] = K_I;
                pick       = $urandom_range(0, 4);
                opArr[i]   = (pick == 0) ? 0 : pick + 1;  // No subi
                imm12      = 12'($urandom_range(0, 4095));
                immArr[i]  = wordT'(imm12);               // Sign-extended
            end else if (pick < 85) begin
                kindArr[i] = (pick < 72) ? K_LW : K_SW;
                rs1Arr[i]  = '0;                          // x0 base with small word offsets
                immArr[i]  = wordT'(4 * $urandom_range(0, 15));
            end else begin
                kindArr[i] = K_BR;
                opArr[i]   = $urandom_range(0, 1);
                // Forward only and never past the end loop
                immArr[i]  = wordT'(4 * $urandom_range(1, (NUM_RAND - i < 6) ? NUM_RAND - i : 6));
            end
            progWord[i] = encodeInst(i);
        end
        kindArr[NUM_RAND]  = K_BR;  // beq x0,x0,0
        opArr[NUM_RAND]    = 0;
        rdArr[NUM_RAND]    = '0;
        rs1Arr[NUM_RAND]   = '0;
        rs2Arr[NUM_RAND]   = '0;
        immArr[NUM_RAND]   = '0;
        progWord[NUM_RAND] = encodeInst(NUM_RAND);
    endtask

    task automatic checkIdle();
        checkFlag("retireValid", retireValid, 1'b0);
        checkFlag("wbEn", wbEn, 1'b0);
        checkFlag("storeEn", storeEn, 1'b0);
        checkWord("pc", pc, '0);
    endtask

    // One model step against the DUT's outputs for the current cycle
    task automatic retireAndCheck();
        int idx;
        wordT a;
        wordT b;
        wordT res;
        wordT addr;
        wordT nextPc;
        logic expWb;
        logic expStore;
        idx      = int'(modelPc >> 2);
        a        = modelRegs[rs1Arr[idx]];
        b        = modelRegs[rs2Arr[idx]];
        res      = '0;
        addr     = a + immArr[idx];
        nextPc   = modelPc + 32'd4;
        expWb    = kindArr[idx] inside {K_R, K_I, K_LW};
        expStore = (kindArr[idx] == K_SW);
        case (kindArr[idx])
            K_R:  res = aluModel(opArr[idx], a, b);
            K_I:  res = aluModel(opArr[idx], a, immArr[idx]);
            K_LW: res = modelMem[int'((addr >> 2) % DMEM_DEPTH)];
            K_BR: begin
                if ((a == b) != (opArr[idx] == 1)) begin
                    nextPc = modelPc + immArr[idx];  // Taken
                end
            end
            default: ;
        endcase
        if (rdArr[idx] == '0) begin
            expWb = 1'b0;  // x0 is never shown as written
        end
        checkFlag("retireValid", retireValid, 1'b1);
        checkWord("pc", pc, modelPc);
        checkFlag("wbEn", wbEn, expWb);
        if (expWb) begin
            checkReg("wbReg", wbReg, rdArr[idx]);
            checkWord("wbData", wbData, res);
            modelRegs[rdArr[idx]] = res;
        end
        checkFlag("storeEn", storeEn, expStore);
        if (expStore) begin
            checkWord("storeAddr", storeAddr, addr);
            checkWord("storeData", storeData, b);
            modelMem[int'((addr >> 2) % DMEM_DEPTH)] = b;
        end
        modelPc = nextPc;
    endtask

    // Cycle limit
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        stopWithError("timeout: the core did not reach the end loop");
    end

    initial begin
        rst      <= 1'b1;
        run      <= 1'b0;
        loadEn   <= 1'b0;
        loadAddr <= '0;
        loadData <= '0;
        void'($urandom(32'h145d1088));
        buildProgram();
        modelPc = '0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int m = 0; m < DMEM_DEPTH; m++) begin
            modelMem[m] = '0;  // DUT memory is cleared by reset
        end
        repeat (3) begin
            @(posedge CLK);
            @(negedge CLK);
            checkIdle();
        end
        @(posedge CLK);
        rst <= 1'b0;       // Four edges seen with rst high
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge CLK);
            loadEn   <= 1'b1;
            loadAddr <= wordT'(i);
            loadData <= progWord[i];
            @(negedge CLK);
            checkIdle();   // Stalled while loading
        end
        @(posedge CLK);
        loadEn <= 1'b0;
        run    <= 1'b1;
        while (modelPc != END_PC) begin
            @(negedge CLK);  // Outputs settled mid-cycle
            retireAndCheck();
        end
        repeat (4) begin
            @(negedge CLK);
            retireAndCheck();  // pc repeats in the end loop
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: singleCpu.f
common/rvIsaPkg.sv
common/cpuCtrlPkg.sv
common/ctrlIf.sv
fetch/fetchUnit.sv
logic/instDecoder.sv
logic/regFile.sv
logic/aluUnit.sv
logic/dataMem.sv
logic/singleCpu.sv
bench/singleCpu_asserts.sv
bench/singleCpu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module singleCpu_tb -f singleCpu.f -o singleCpuSim

out=$(./obj_dir/singleCpuSim 2>&1) || true
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
